//--- Bender.yml
package:
  name: backprop_accum

export_include_dirs:
  - include

sources:
  - design/backprop_pkg.sv
  - design/acc_if.sv
  - design/backprop_ctrl.sv
  - design/loss_unit.sv
  - design/backprop_terms.sv
  - design/grad_accum.sv
  - design/param_update.sv
  - design/backprop_top.sv
  - target: simulation
    files:
      - testbench/backprop_asserts.sv
      - testbench/tb_backprop.sv

//--- design/acc_if.sv
// Interface for gradient terms and accumulate/clear controls, with modports
`default_nettype none

interface acc_if;
  import backprop_pkg::*;

  // Per-sample gradient contributions
  w_vec_t w_term;
  b_vec_t b_term;

  // Add the current terms this cycle
  logic acc_en;
  // Zero all accumulators and the cost
  logic clear;

  modport terms (output w_term, output b_term);
  modport ctrl (output acc_en, output clear);
  modport bank (input w_term, input b_term, input acc_en, input clear);

endinterface

`default_nettype wire

//--- design/backprop_ctrl.sv
// Controller: sample acceptance, drain sequencing, stream index and clear pulse
`default_nettype none

`include "backprop_defines.svh"

module backprop_ctrl (
  input  logic                dtb,
  input  logic                rst_n,
  input  logic                sample_valid,
  input  logic                drain_start,
  acc_if.ctrl                 acc,
  output backprop_pkg::pidx_t param_index,
  output logic                param_valid,
  output logic                busy,
  output logic                drain_done
);
  import backprop_pkg::*;

  // Idle, streaming parameters, one cycle of wrap-up
  typedef enum logic [1:0] {
    st_idle,
    st_drain,
    st_done
  } state_t;

  localparam pidx_t last_idx = pidx_t'(`BP_NP - 1);

  state_t state;
  pidx_t  idx;

  always_ff @(posedge dtb or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      idx   <= '0;
    end else begin
      case (state)
        st_idle: begin
          // Drain requests only count while idle
          if (drain_start) begin
            state <= st_drain;
            idx   <= '0;
          end
        end
        st_drain: begin
          if (idx == last_idx) begin
            state <= st_done;
          end else begin
            idx <= idx + pidx_t'(1);
          end
        end
        default: begin
          // Clear cycle, back to idle after it
          state <= st_idle;
        end
      endcase
    end
  end

  // Busy spans the stream and the clear cycle
  assign busy        = (state != st_idle);
  assign param_valid = (state == st_drain);
  assign drain_done  = (state == st_done);
  assign param_index = idx;

  // Samples accumulate on the edge where they are seen, unless draining
  assign acc.acc_en = sample_valid & ~busy;
  assign acc.clear  = drain_done;

endmodule

`default_nettype wire

//--- design/backprop_pkg.sv
// Fixed-point word and vector types, stream index type, truncating multiply
`default_nettype none

`include "backprop_defines.svh"

package backprop_pkg;

  // One signed Q8.8 word
  typedef logic signed [`BP_N-1:0] fix_t;

  // Activation and target vectors, element 0 is the first node
  typedef fix_t [`BP_NX-1:0] in_vec_t;
  typedef fix_t [`BP_NH-1:0] hid_vec_t;
  typedef fix_t [`BP_NO-1:0] out_vec_t;

  // Layer-1 weights first (j*NX+i), then layer-2 (NX*NH + k*NH + j)
  typedef fix_t [`BP_NW-1:0] w_vec_t;
  // Hidden biases first, then output biases
  typedef fix_t [`BP_NB-1:0] b_vec_t;

  // Position in the drain stream
  typedef logic [$clog2(`BP_NP)-1:0] pidx_t;

  // Full 32-bit product, keep bits 23 down to 8
  function automatic fix_t fix_mul(input fix_t a, input fix_t b);
    logic signed [2*`BP_N-1:0] prod;
    prod = a * b;
    return prod[`BP_N+`BP_F-1:`BP_F];
  endfunction

endpackage

`default_nettype wire

//--- design/backprop_terms.sv
// Hidden errors plus every weight and bias gradient term of one sample
`default_nettype none

`include "backprop_defines.svh"

module backprop_terms (
  acc_if.terms                   acc,
  input  backprop_pkg::in_vec_t  x,
  input  backprop_pkg::hid_vec_t y_hid,
  input  backprop_pkg::out_vec_t err_out,
  input  backprop_pkg::w_vec_t   w
);
  import backprop_pkg::*;

  // Offset of the layer-2 weights inside the weight vector
  localparam int w2_base = `BP_NX * `BP_NH;

  hid_vec_t err_hid;
  w_vec_t   w_t;
  b_vec_t   b_t;

  always_comb begin
    fix_t back_sum;

    // Hidden error: back-propagated output errors, gated by ReLU step
    for (int j = 0; j < `BP_NH; j++) begin
      back_sum = '0;
      for (int k = 0; k < `BP_NO; k++) begin
        back_sum = back_sum + fix_mul(err_out[k], w[w2_base + k*`BP_NH + j]);
      end
      err_hid[j] = (y_hid[j] >= fix_t'(0)) ? back_sum : fix_t'(0);
    end

    // Layer-1 gradient: hidden error times the input feeding it
    for (int j = 0; j < `BP_NH; j++) begin
      for (int i = 0; i < `BP_NX; i++) begin
        w_t[j*`BP_NX + i] = fix_mul(err_hid[j], x[i]);
      end
    end

    // Layer-2 gradient: output error times hidden activation
    for (int k = 0; k < `BP_NO; k++) begin
      for (int j = 0; j < `BP_NH; j++) begin
        w_t[w2_base + k*`BP_NH + j] = fix_mul(err_out[k], y_hid[j]);
      end
    end

    // Bias gradient is the node error itself
    for (int j = 0; j < `BP_NH; j++) begin
      b_t[j] = err_hid[j];
    end
    for (int k = 0; k < `BP_NO; k++) begin
      b_t[`BP_NH + k] = err_out[k];
    end
  end

  assign acc.w_term = w_t;
  assign acc.b_term = b_t;

endmodule

`default_nettype wire

//--- design/backprop_top.sv
// Top level: controller, loss, gradient terms, accumulator banks, update mux
`default_nettype none

module backprop_top (
  input  logic                   dtb,
  input  logic                   rst_n,
  input  logic                   sample_valid,
  input  logic                   drain_start,
  input  backprop_pkg::in_vec_t  x,
  input  backprop_pkg::hid_vec_t y_hid,
  input  backprop_pkg::out_vec_t y_out,
  input  backprop_pkg::out_vec_t target,
  input  backprop_pkg::w_vec_t   w,
  input  backprop_pkg::b_vec_t   b,
  output logic                   param_valid,
  output logic                   busy,
  output logic                   drain_done,
  output backprop_pkg::pidx_t    param_index,
  output backprop_pkg::fix_t     param_value,
  output backprop_pkg::fix_t     cost
);
  import backprop_pkg::*;

  // Terms and controls shared by the datapath blocks
  acc_if acc ();

  out_vec_t err_out;
  w_vec_t   w_sum;
  b_vec_t   b_sum;

  backprop_ctrl u_ctrl (
    .dtb          (dtb),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .drain_start  (drain_start),
    .acc          (acc.ctrl),
    .param_index  (param_index),
    .param_valid  (param_valid),
    .busy         (busy),
    .drain_done   (drain_done)
  );

  loss_unit u_loss (
    .dtb     (dtb),
    .rst_n   (rst_n),
    .acc     (acc.bank),
    .y_out   (y_out),
    .target  (target),
    .err_out (err_out),
    .cost    (cost)
  );

  backprop_terms u_terms (
    .acc     (acc.terms),
    .x       (x),
    .y_hid   (y_hid),
    .err_out (err_out),
    .w       (w)
  );

  // Weight gradients
  grad_accum #(.payload_t(w_vec_t), .sel_bias(1'b0)) u_w_acc (
    .dtb   (dtb),
    .rst_n (rst_n),
    .acc   (acc.bank),
    .sum   (w_sum)
  );

  // Bias gradients
  grad_accum #(.payload_t(b_vec_t), .sel_bias(1'b1)) u_b_acc (
    .dtb   (dtb),
    .rst_n (rst_n),
    .acc   (acc.bank),
    .sum   (b_sum)
  );

  param_update u_update (
    .param_index (param_index),
    .w           (w),
    .w_sum       (w_sum),
    .b           (b),
    .b_sum       (b_sum),
    .param_value (param_value)
  );

endmodule

`default_nettype wire

//--- design/grad_accum.sv
// Gradient accumulator bank, payload given by a type parameter
`default_nettype none

`include "backprop_defines.svh"

module grad_accum #(
  parameter type payload_t = backprop_pkg::w_vec_t,
  parameter bit  sel_bias  = 1'b0
) (
  input  logic dtb,
  input  logic rst_n,
  acc_if.bank  acc,
  output payload_t sum
);
  import backprop_pkg::*;

  // Words in one payload
  localparam int n_elem = $bits(payload_t) / `BP_N;

  logic [$bits(payload_t)-1:0] term_flat;
  logic [$bits(payload_t)-1:0] sum_flat;

  // Pick which term vector feeds this bank
  if (sel_bias) begin : g_bias
    assign term_flat = acc.b_term;
  end else begin : g_weight
    assign term_flat = acc.w_term;
  end

  always_ff @(posedge dtb or negedge rst_n) begin
    if (!rst_n) begin
      sum_flat <= '0;
    end else if (acc.clear) begin
      sum_flat <= '0;
    end else if (acc.acc_en) begin
      // Element-wise wrapping add
      for (int e = 0; e < n_elem; e++) begin
        sum_flat[e*`BP_N +: `BP_N] <= fix_t'(sum_flat[e*`BP_N +: `BP_N])
                                    + fix_t'(term_flat[e*`BP_N +: `BP_N]);
      end
    end
  end

  assign sum = payload_t'(sum_flat);

endmodule

`default_nettype wire

//--- design/loss_unit.sv
// Output error with ReLU derivative and the squared-error cost register
`default_nettype none

`include "backprop_defines.svh"

module loss_unit (
  input  logic                   dtb,
  input  logic                   rst_n,
  acc_if.bank                    acc,
  input  backprop_pkg::out_vec_t y_out,
  input  backprop_pkg::out_vec_t target,
  output backprop_pkg::out_vec_t err_out,
  output backprop_pkg::fix_t     cost
);
  import backprop_pkg::*;

  out_vec_t diff;
  fix_t     sq_sum;

  always_comb begin
    sq_sum = '0;
    for (int k = 0; k < `BP_NO; k++) begin
      // Difference wraps in 16 bits
      diff[k] = y_out[k] - target[k];
      // ReLU derivative is a step, so the error is the difference or zero
      err_out[k] = (y_out[k] >= fix_t'(0)) ? diff[k] : fix_t'(0);
      sq_sum = sq_sum + fix_mul(diff[k], diff[k]);
    end
  end

  // Plain sum of squared errors over all accepted samples
  always_ff @(posedge dtb or negedge rst_n) begin
    if (!rst_n) begin
      cost <= '0;
    end else if (acc.clear) begin
      cost <= '0;
    end else if (acc.acc_en) begin
      cost <= cost + sq_sum;
    end
  end

endmodule

`default_nettype wire

//--- design/param_update.sv
// Stream index decode and updated value: old minus rate times gradient
`default_nettype none

`include "backprop_defines.svh"

module param_update (
  input  backprop_pkg::pidx_t  param_index,
  input  backprop_pkg::w_vec_t w,
  input  backprop_pkg::w_vec_t w_sum,
  input  backprop_pkg::b_vec_t b,
  input  backprop_pkg::b_vec_t b_sum,
  output backprop_pkg::fix_t   param_value
);
  import backprop_pkg::*;

  localparam int w2_base = `BP_NX * `BP_NH;

  fix_t old_v;
  fix_t grad_v;

  // Walk the stream order and pick the element at param_index
  always_comb begin
    int pos;

    pos    = 0;
    old_v  = '0;
    grad_v = '0;

    // Each hidden node: its input weights, then its bias
    for (int j = 0; j < `BP_NH; j++) begin
      for (int i = 0; i < `BP_NX; i++) begin
        if (param_index == pidx_t'(pos)) begin
          old_v  = w[j*`BP_NX + i];
          grad_v = w_sum[j*`BP_NX + i];
        end
        pos++;
      end
      if (param_index == pidx_t'(pos)) begin
        old_v  = b[j];
        grad_v = b_sum[j];
      end
      pos++;
    end

    // Each output node: weights from the hidden layer, then its bias
    for (int k = 0; k < `BP_NO; k++) begin
      for (int j = 0; j < `BP_NH; j++) begin
        if (param_index == pidx_t'(pos)) begin
          old_v  = w[w2_base + k*`BP_NH + j];
          grad_v = w_sum[w2_base + k*`BP_NH + j];
        end
        pos++;
      end
      if (param_index == pidx_t'(pos)) begin
        old_v  = b[`BP_NH + k];
        grad_v = b_sum[`BP_NH + k];
      end
      pos++;
    end
  end

  // Gradient descent step, products truncated like everywhere else
  assign param_value = old_v - fix_mul(fix_t'(`BP_RATE), grad_v);

endmodule

`default_nettype wire

//--- include/backprop_defines.svh
// Word format, network sizes, parameter counts and learning rate macros
`ifndef BACKPROP_DEFINES_SVH
`define BACKPROP_DEFINES_SVH

// Q8.8 two's complement word
`define BP_N 16
`define BP_F 8

// Network shape: inputs, one hidden layer, outputs
`define BP_NX 2
`define BP_NH 2
`define BP_NO 2

// Learning rate, roughly 0.1 in Q8.8
`define BP_RATE 16'h0019

// Parameter counts
`define BP_NW (`BP_NX * `BP_NH + `BP_NH * `BP_NO)
`define BP_NB (`BP_NH + `BP_NO)
`define BP_NP (`BP_NW + `BP_NB)

`endif

//--- testbench/backprop_asserts.sv
// Bound protocol assertions for the drain stream, done pulse and reset state
`default_nettype none

`include "backprop_defines.svh"

module backprop_asserts (
  input logic                dtb,
  input logic                rst_n,
  input logic                param_valid,
  input logic                busy,
  input logic                drain_done,
  input backprop_pkg::pidx_t param_index
);
  timeunit 1ns;
  timeprecision 100ps;

  import backprop_pkg::*;

  localparam pidx_t last_idx = pidx_t'(`BP_NP - 1);

  // Failures seen so far, watched by the testbench
  int unsigned fail_count = 0;

  // Stream only inside a busy window
  a_valid_busy: assert property (@(posedge dtb) disable iff (!rst_n)
    param_valid |-> busy)
    else begin
      fail_count++;
      $error("param_valid high while not busy");
    end

  // Every stream opens at index 0
  a_first_idx: assert property (@(posedge dtb) disable iff (!rst_n)
    $rose(param_valid) |-> param_index == '0)
    else begin
      fail_count++;
      $error("drain stream did not start at index 0");
    end

  // Index steps by one until the last parameter
  a_step_idx: assert property (@(posedge dtb) disable iff (!rst_n)
    param_valid && param_index != last_idx
    |=> param_valid && param_index == $past(param_index) + pidx_t'(1))
    else begin
      fail_count++;
      $error("drain stream broke off or skipped an index");
    end

  // After the last index the stream stops and done follows
  a_last_idx: assert property (@(posedge dtb) disable iff (!rst_n)
    param_valid && param_index == last_idx |=> !param_valid && drain_done)
    else begin
      fail_count++;
      $error("stream did not end with drain_done after the last index");
    end

  // Done lasts a single cycle
  a_done_pulse: assert property (@(posedge dtb) disable iff (!rst_n)
    drain_done |=> !drain_done)
    else begin
      fail_count++;
      $error("drain_done held longer than one cycle");
    end

  // Done only ever comes right after the last index
  a_done_cause: assert property (@(posedge dtb) disable iff (!rst_n)
    drain_done |-> $past(param_valid && param_index == last_idx))
    else begin
      fail_count++;
      $error("drain_done without a preceding last index");
    end

  // Control outputs quiet under reset
  a_reset_low: assert property (@(posedge dtb)
    !rst_n |-> !busy && !param_valid && !drain_done)
    else begin
      fail_count++;
      $error("control output high during reset");
    end

endmodule

bind backprop_top backprop_asserts u_asserts (
  .dtb         (dtb),
  .rst_n       (rst_n),
  .param_valid (param_valid),
  .busy        (busy),
  .drain_done  (drain_done),
  .param_index (param_index)
);

`default_nettype wire

//--- testbench/tb_backprop.sv
// Testbench with clock, reset, random samples, reference model, value checks and watchdog
`default_nettype none

`include "backprop_defines.svh"

module tb_backprop;
  timeunit 1ns;
  timeprecision 100ps;

  import backprop_pkg::*;

  localparam int clk_period = 40;
  // Sample and drain counts of the sequence below, they size the watchdog
  localparam int n_samples  = 13;
  localparam int n_drains   = 6;
  localparam int wd_cycles  = n_samples + n_drains * (`BP_NP + 4) + 50;

  logic     dtb;
  logic     rst_n;
  logic     sample_valid;
  logic     drain_start;
  in_vec_t  x;
  hid_vec_t y_hid;
  out_vec_t y_out;
  out_vec_t target;
  w_vec_t   w;
  b_vec_t   b;
  logic     param_valid;
  logic     busy;
  logic     drain_done;
  pidx_t    param_index;
  fix_t     param_value;
  fix_t     cost;

  // Reference accumulators, cost and expected drain stream
  shortint ref_w[`BP_NW];
  shortint ref_b[`BP_NB];
  shortint ref_cost;
  shortint exp_stream[`BP_NP];

  backprop_top u_dut (.*);

  initial begin
    dtb = 1'b0;
    forever #(clk_period / 2) dtb = ~dtb;
  end

  // Q8.8 product truncated to bits 23..8 of the 32-bit result
  function automatic shortint qmul(input shortint a, input shortint c);
    int p;
    p = int'(a) * int'(c);
    return shortint'(p >>> `BP_F);
  endfunction

  // Random word within +-2.0, or within 0..2.0 when nonneg is set
  function automatic shortint rand_word(input bit nonneg);
    int v;
    if (nonneg) begin
      v = $urandom_range(512, 0);
    end else begin
      v = int'($urandom_range(1024, 0)) - 512;
    end
    return shortint'(v);
  endfunction

  // One descent step on a single parameter
  function automatic shortint step_param(input shortint old_v, input shortint grad);
    return old_v - qmul(shortint'(`BP_RATE), grad);
  endfunction

  task automatic check_word(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    assert (actual === expected) else begin
      $display("FAILED time=%0t signal=%s expected=%h actual=%h",
               $time, name, expected, actual);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic clear_model();
    ref_w    = '{default: 0};
    ref_b    = '{default: 0};
    ref_cost = 0;
  endtask

  // Adds the current inputs as one sample to the model
  task automatic model_sample();
    shortint d[`BP_NO];
    shortint eo[`BP_NO];
    shortint eh[`BP_NH];
    shortint s;
    for (int k = 0; k < `BP_NO; k++) begin
      d[k] = y_out[k] - target[k];
      // Sign bit set means ReLU slope 0
      eo[k] = y_out[k][`BP_N-1] ? shortint'(0) : d[k];
      ref_cost += qmul(d[k], d[k]);
    end
    for (int j = 0; j < `BP_NH; j++) begin
      s = 0;
      for (int k = 0; k < `BP_NO; k++) begin
        s += qmul(eo[k], w[`BP_NX*`BP_NH + k*`BP_NH + j]);
      end
      eh[j] = y_hid[j][`BP_N-1] ? shortint'(0) : s;
      ref_b[j] += eh[j];
      for (int i = 0; i < `BP_NX; i++) begin
        ref_w[j*`BP_NX + i] += qmul(eh[j], x[i]);
      end
    end
    for (int k = 0; k < `BP_NO; k++) begin
      ref_b[`BP_NH + k] += eo[k];
      for (int j = 0; j < `BP_NH; j++) begin
        ref_w[`BP_NX*`BP_NH + k*`BP_NH + j] += qmul(eo[k], y_hid[j]);
      end
    end
  endtask

  // Expected stream in drain order, hidden nodes before output nodes
  task automatic build_expected();
    int n;
    int wi;
    n = 0;
    for (int j = 0; j < `BP_NH; j++) begin
      for (int i = 0; i < `BP_NX; i++) begin
        wi = j*`BP_NX + i;
        exp_stream[n] = step_param(w[wi], ref_w[wi]);
        n++;
      end
      exp_stream[n] = step_param(b[j], ref_b[j]);
      n++;
    end
    for (int k = 0; k < `BP_NO; k++) begin
      for (int j = 0; j < `BP_NH; j++) begin
        wi = `BP_NX*`BP_NH + k*`BP_NH + j;
        exp_stream[n] = step_param(w[wi], ref_w[wi]);
        n++;
      end
      exp_stream[n] = step_param(b[`BP_NH + k], ref_b[`BP_NH + k]);
      n++;
    end
  endtask

  // neg forces a negative hidden and output activation
  task automatic drive_inputs(input bit neg);
    for (int i = 0; i < `BP_NX; i++) begin
      x[i] = rand_word(1'b0);
    end
    for (int j = 0; j < `BP_NH; j++) begin
      y_hid[j] = rand_word(!neg);
    end
    for (int k = 0; k < `BP_NO; k++) begin
      y_out[k]  = rand_word(!neg);
      target[k] = rand_word(1'b0);
    end
    if (neg) begin
      y_hid[1] = fix_t'(-int'($urandom_range(512, 1)));
      y_out[0] = fix_t'(-int'($urandom_range(512, 1)));
    end
  endtask

  // Called on a falling edge and returns on the next one
  task automatic send_sample(input bit neg);
    drive_inputs(neg);
    sample_valid = 1'b1;
    model_sample();
    @(negedge dtb);
  endtask

  // poke drives samples and drain requests during the stream and the done cycle
  task automatic drain_and_check(input bit poke);
    int n;
    n = 0;
    build_expected();
    drain_start = 1'b1;
    @(negedge dtb);
    drain_start = 1'b0;
    check_word("busy", 16'd1, 16'(busy));
    while (!drain_done) begin
      if (param_valid) begin
        check_word("param_index", 16'(n), 16'(param_index));
        check_word("param_value", exp_stream[n], param_value);
        n++;
      end
      if (poke) begin
        drive_inputs(1'b0);
        sample_valid = 1'b1;
        drain_start  = 1'b1;
      end
      @(negedge dtb);
    end
    check_word("param_count", 16'(`BP_NP), 16'(n));
    @(negedge dtb);
    sample_valid = 1'b0;
    drain_start  = 1'b0;
    // Accumulators cleared with the done pulse
    check_word("busy", 16'd0, 16'(busy));
    check_word("cost", 16'd0, cost);
    clear_model();
  endtask

  initial begin
    void'($urandom(94269));
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    drain_start  = 1'b0;
    x            = '0;
    y_hid        = '0;
    y_out        = '0;
    target       = '0;
    for (int e = 0; e < `BP_NW; e++) begin
      w[e] = rand_word(1'b0);
    end
    for (int e = 0; e < `BP_NB; e++) begin
      b[e] = rand_word(1'b0);
    end
    clear_model();
    repeat (5) @(negedge dtb);
    rst_n = 1'b1;
    @(negedge dtb);

    // Empty drain returns the parameters unchanged
    check_word("cost", 16'd0, cost);
    drain_and_check(1'b0);

    // Separated samples with non-negative activations
    repeat (3) begin
      send_sample(1'b0);
      sample_valid = 1'b0;
      @(negedge dtb);
    end
    check_word("cost", ref_cost, cost);
    drain_and_check(1'b0);

    // Negative activations gate errors
    repeat (3) begin
      send_sample(1'b1);
      sample_valid = 1'b0;
      @(negedge dtb);
    end
    check_word("cost", ref_cost, cost);
    drain_and_check(1'b0);

    // Back-to-back samples
    repeat (4) send_sample(1'b0);
    sample_valid = 1'b0;
    check_word("cost", ref_cost, cost);
    drain_and_check(1'b0);

    // Requests during a drain are dropped and a second drain is clean
    repeat (3) send_sample(1'b0);
    sample_valid = 1'b0;
    check_word("cost", ref_cost, cost);
    drain_and_check(1'b1);
    drain_and_check(1'b0);

    if (u_dut.u_asserts.fail_count != 0) begin
      $display("CHECKS FAILED");
      $fatal(1, "protocol assertions failed during the run");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

  // Stop at the first bound assertion failure
  initial begin
    wait (u_dut.u_asserts.fail_count != 0);
    $display("A bound protocol assertion failed at time %0t", $time);
    $display("CHECKS FAILED");
    $fatal(1, "protocol violation");
  end

  initial begin
    #(wd_cycles * clk_period);
    $display("Timeout: the test sequence did not finish in %0d cycles", wd_cycles);
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
design/backprop_pkg.sv
design/acc_if.sv
design/backprop_ctrl.sv
design/loss_unit.sv
design/backprop_terms.sv
design/grad_accum.sv
design/param_update.sv
design/backprop_top.sv
testbench/backprop_asserts.sv
testbench/tb_backprop.sv
